/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= rv_pipeline_tb
FILELIST  ?= rv_pipeline.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "TESTBENCH FAILED" $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* hw/decode_stage.sv */
module decode_stage
  import rv_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  logic          redirect,
  input  decode_slot_t  decode_slot,
  fwd_if.sink           fwd,
  output execute_slot_t execute_slot
);

  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rf_rs1_data;
  word_t    rf_rs2_data;
  word_t    rs1_data;
  word_t    rs2_data;

  assign rs1 = decode_slot.insn[19:15];
  assign rs2 = decode_slot.insn[24:20];

  reg_file rf (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rf_rs1_data),
    .rs2_data (rf_rs2_data),
    .wr       (fwd)
  );

  // the register being written this cycle is not in the array yet
  assign rs1_data = (fwd.w_valid && fwd.w_rd == rs1) ? fwd.w_result : rf_rs1_data;
  assign rs2_data = (fwd.w_valid && fwd.w_rd == rs2) ? fwd.w_result : rf_rs2_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      execute_slot <= '{base: reset_decode_slot, rs1_data: '0, rs2_data: '0};
    end else if (redirect) begin
      execute_slot <= '{base: flush_decode_slot, rs1_data: '0, rs2_data: '0};
    end else begin
      execute_slot <= '{base: decode_slot, rs1_data: rs1_data, rs2_data: rs2_data};
    end
  end

endmodule

/* hw/execute_stage.sv */
module execute_stage
  import rv_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  execute_slot_t execute_slot,
  fwd_if.mem_src        fwd_src,
  fwd_if.sink           fwd,
  output logic          redirect,
  output word_t         redirect_pc,
  output logic          halt,
  output retire_slot_t  retire_slot
);

  word_t    pc;
  insn_t    insn;
  opcode_e  opcode;
  logic [2:0] funct3;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    imm_i;
  word_t    imm_b;
  word_t    imm_u;
  word_t    rs1_val;
  word_t    rs2_val;
  word_t    alu_b;
  word_t    alu_out;
  word_t    result;
  logic     writes_rd;
  logic     cond;
  logic     ecall;

  assign pc     = execute_slot.base.pc;
  assign insn   = execute_slot.base.insn;
  assign opcode = opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  // memory forward is younger, so it wins over writeback
  assign rs1_val = (fwd.m_valid && fwd.m_rd == rs1) ? fwd.m_result :
                   (fwd.w_valid && fwd.w_rd == rs1) ? fwd.w_result : execute_slot.rs1_data;
  assign rs2_val = (fwd.m_valid && fwd.m_rd == rs2) ? fwd.m_result :
                   (fwd.w_valid && fwd.w_rd == rs2) ? fwd.w_result : execute_slot.rs2_data;

  // reg-imm and reg-reg share one ALU, only operand b differs
  assign alu_b = (opcode == op_reg_reg) ? rs2_val : imm_i;

  always_comb begin
    case (funct3)
      3'b000: begin
        if (opcode == op_reg_reg && insn[30]) alu_out = rs1_val - alu_b;
        else alu_out = rs1_val + alu_b;
      end
      3'b001: alu_out = rs1_val << alu_b[4:0];
      3'b010: alu_out = {31'b0, $signed(rs1_val) < $signed(alu_b)};
      3'b011: alu_out = {31'b0, rs1_val < alu_b};
      3'b100: alu_out = rs1_val ^ alu_b;
      3'b101: begin
        if (insn[30]) alu_out = $signed(rs1_val) >>> alu_b[4:0];
        else alu_out = rs1_val >> alu_b[4:0];
      end
      3'b110: alu_out = rs1_val | alu_b;
      default: alu_out = rs1_val & alu_b;
    endcase
  end

  always_comb begin
    writes_rd = 1'b1;
    case (opcode)
      op_reg_imm, op_reg_reg: result = alu_out;
      op_lui: result = imm_u;
      op_auipc: result = pc + imm_u;
      default: begin
        result = '0;
        writes_rd = 1'b0;
      end
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000: cond = rs1_val == rs2_val;
      3'b001: cond = rs1_val != rs2_val;
      3'b100: cond = $signed(rs1_val) < $signed(rs2_val);
      3'b101: cond = $signed(rs1_val) >= $signed(rs2_val);
      3'b110: cond = rs1_val < rs2_val;
      3'b111: cond = rs1_val >= rs2_val;
      default: cond = 1'b0;
    endcase
  end

  assign redirect    = (opcode == op_branch) && cond;
  assign redirect_pc = pc + imm_b;
  assign ecall       = (opcode == op_environ) && (insn[31:7] == 25'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      halt        <= 1'b0;
      retire_slot <= reset_retire_slot;
    end else begin
      halt        <= ecall;
      retire_slot <= '{pc: pc, insn: insn, status: execute_slot.base.status,
                       result: result, rd: writes_rd ? insn[11:7] : 5'd0};
    end
  end

  // the memory stage does no work, its register is the forward source
  assign fwd_src.m_valid  = retire_slot.rd != 5'd0;
  assign fwd_src.m_rd     = retire_slot.rd;
  assign fwd_src.m_result = retire_slot.result;

endmodule

/* hw/fetch_stage.sv */
module fetch_stage
  import rv_pkg::*;
#(
  parameter word_t reset_pc = '0
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         redirect,
  input  word_t        redirect_pc,
  output word_t        imem_pc,
  input  insn_t        imem_insn,
  output decode_slot_t decode_slot
);

  word_t pc;

  assign imem_pc = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else begin
      pc <= pc + 32'd4;
    end
  end

  // the word fetched this cycle is squashed when a branch is taken in execute
  always_ff @(posedge clk) begin
    if (rst) begin
      decode_slot <= reset_decode_slot;
    end else if (redirect) begin
      decode_slot <= flush_decode_slot;
    end else begin
      decode_slot <= '{pc: pc, insn: imem_insn, status: cycle_no_stall};
    end
  end

endmodule

/* hw/fwd_if.sv */
interface fwd_if
  import rv_pkg::*;
();

  // memory stage source
  logic     m_valid;
  reg_idx_t m_rd;
  word_t    m_result;

  // writeback stage source, also the register file write port
  logic     w_valid;
  reg_idx_t w_rd;
  word_t    w_result;

  modport mem_src (output m_valid, m_rd, m_result);
  modport wb_src (output w_valid, w_rd, w_result);
  modport sink (input m_valid, m_rd, m_result, w_valid, w_rd, w_result);

endinterface

/* hw/reg_file.sv */
module reg_file
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rs1_data,
  output word_t    rs2_data,
  fwd_if.sink      wr
);

  word_t regs [32];

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // w_valid is never set for x0, so entry 0 stays zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.w_valid) begin
      regs[wr.w_rd] <= wr.w_result;
    end
  end

endmodule

/* hw/rv_pipeline.sv */
module rv_pipeline
  import rv_pkg::*;
#(
  parameter word_t reset_pc = '0
) (
  input  logic          clk,
  input  logic          rst,
  output word_t         imem_pc,
  input  insn_t         imem_insn,
  output logic          halt,
  output word_t         trace_pc,
  output insn_t         trace_insn,
  output cycle_status_e trace_status,
  output word_t         trace_data
);

  logic          redirect;
  word_t         redirect_pc;
  decode_slot_t  decode_slot;
  execute_slot_t execute_slot;
  retire_slot_t  retire_slot;

  fwd_if fwd ();

  fetch_stage #(
    .reset_pc (reset_pc)
  ) u_fetch (
    .clk         (clk),
    .rst         (rst),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .imem_pc     (imem_pc),
    .imem_insn   (imem_insn),
    .decode_slot (decode_slot)
  );

  decode_stage u_decode (
    .clk          (clk),
    .rst          (rst),
    .redirect     (redirect),
    .decode_slot  (decode_slot),
    .fwd          (fwd),
    .execute_slot (execute_slot)
  );

  execute_stage u_execute (
    .clk          (clk),
    .rst          (rst),
    .execute_slot (execute_slot),
    .fwd_src      (fwd),
    .fwd          (fwd),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .halt         (halt),
    .retire_slot  (retire_slot)
  );

  writeback_stage u_writeback (
    .clk          (clk),
    .rst          (rst),
    .retire_slot  (retire_slot),
    .fwd_src      (fwd),
    .trace_pc     (trace_pc),
    .trace_insn   (trace_insn),
    .trace_status (trace_status),
    .trace_data   (trace_data)
  );

endmodule

/* hw/rv_pkg.sv */
package rv_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [31:0] insn_t;
  typedef logic [4:0] reg_idx_t;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    op_reg_imm = 7'b0010011,
    op_reg_reg = 7'b0110011,
    op_branch  = 7'b1100011,
    op_lui     = 7'b0110111,
    op_auipc   = 7'b0010111,
    op_environ = 7'b1110011
  } opcode_e;

  // what occupies a pipeline slot
  typedef enum logic [1:0] {
    cycle_reset,
    cycle_no_stall,
    cycle_taken_branch
  } cycle_status_e;

  localparam insn_t nop_insn = 32'h0000_0000;

  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    cycle_status_e status;
  } decode_slot_t;

  typedef struct packed {
    decode_slot_t base;
    word_t        rs1_data;
    word_t        rs2_data;
  } execute_slot_t;

  // rd is zero when the instruction writes no register
  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    cycle_status_e status;
    word_t         result;
    reg_idx_t      rd;
  } retire_slot_t;

  localparam decode_slot_t reset_decode_slot = '{pc: '0, insn: nop_insn, status: cycle_reset};
  localparam decode_slot_t flush_decode_slot =
    '{pc: '0, insn: nop_insn, status: cycle_taken_branch};
  localparam retire_slot_t reset_retire_slot =
    '{pc: '0, insn: nop_insn, status: cycle_reset, result: '0, rd: '0};

endpackage

/* hw/writeback_stage.sv */
module writeback_stage
  import rv_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  retire_slot_t  retire_slot,
  fwd_if.wb_src         fwd_src,
  output word_t         trace_pc,
  output insn_t         trace_insn,
  output cycle_status_e trace_status,
  output word_t         trace_data
);

  retire_slot_t wb_slot;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_slot <= reset_retire_slot;
    end else begin
      wb_slot <= retire_slot;
    end
  end

  // register file write and the writeback forward come from the same register
  assign fwd_src.w_valid  = wb_slot.rd != 5'd0;
  assign fwd_src.w_rd     = wb_slot.rd;
  assign fwd_src.w_result = wb_slot.result;

  assign trace_pc     = wb_slot.pc;
  assign trace_insn   = wb_slot.insn;
  assign trace_status = wb_slot.status;
  assign trace_data   = wb_slot.result;

endmodule

/* rv_pipeline.f */
+incdir+sim
hw/rv_pkg.sv
hw/fwd_if.sv
hw/reg_file.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/writeback_stage.sv
hw/rv_pipeline.sv
sim/rv_pipeline_sva.sv
sim/rv_pipeline_tb.sv

/* sim/rv_pipeline_sva.sv */
module rv_pipeline_sva
  import rv_pkg::*;
(
  input logic          clk,
  input logic          rst,
  input logic          halt,
  input word_t         imem_pc,
  input cycle_status_e trace_status,
  input insn_t         trace_insn
);

  // every reset edge clears halt
  halt_cleared: assert property (@(posedge clk) rst |=> !halt)
    else $error("halt set after a reset cycle");

  pc_aligned: assert property (@(posedge clk) disable iff (rst) imem_pc[1:0] == 2'b00)
    else $error("imem_pc is not word aligned");

  // a squashed slot carries the bubble word
  flush_is_bubble: assert property (@(posedge clk) disable iff (rst)
    trace_status == cycle_taken_branch |-> trace_insn == nop_insn)
    else $error("taken-branch slot carries a nonzero instruction");

endmodule

bind rv_pipeline rv_pipeline_sva u_sva (
  .clk          (clk),
  .rst          (rst),
  .halt         (halt),
  .imem_pc      (imem_pc),
  .trace_status (trace_status),
  .trace_insn   (trace_insn)
);

/* sim/rv_model.svh */
localparam int prog_len = 256;
localparam insn_t ecall_insn = 32'h0000_0073;

word_t    rng_state = 32'd64902;
insn_t    prog [prog_len];
word_t    xreg [32];
word_t    model_pc;
reg_idx_t recent [3];

function automatic word_t next_rand();
  rng_state ^= rng_state << 13;
  rng_state ^= rng_state >> 17;
  rng_state ^= rng_state << 5;
  return rng_state;
endfunction

// three sources in four come from the last three destinations
function automatic reg_idx_t pick_src();
  word_t r;
  r = next_rand();
  if (r[1:0] == 2'b00) return r[8:4];
  if (r[3:2] == 2'd3) return recent[0];
  return recent[r[3:2]];
endfunction

task automatic gen_program();
  word_t       r;
  word_t       v;
  reg_idx_t    rd;
  reg_idx_t    s1;
  reg_idx_t    s2;
  logic [2:0]  f3;
  logic [11:0] imm;
  logic [6:0]  f7;
  logic [7:0]  i;
  logic [8:0]  t;
  logic [12:0] off;
  recent = '{5'd1, 5'd2, 5'd3};
  for (int n = 0; n < prog_len - 1; n++) begin
    i = n[7:0];
    r = next_rand();
    v = next_rand();
    rd = v[4:0];
    f3 = v[7:5];
    s1 = pick_src();
    s2 = pick_src();
    if (r[3:0] < 4'd2) begin
      // forward only, and never past the final ecall
      t = {1'b0, i} + 9'd1 + {6'd0, v[10:8]};
      if (t > 9'd255) t = 9'd255;
      off = {2'b00, t - {1'b0, i}, 2'b00};
      if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd2;
      prog[i] = {off[12], off[10:5], s2, s1, f3, off[4:1], off[11], op_branch};
    end else begin
      if (r[3:0] == 4'd2) begin
        prog[i] = {v[31:12], rd, op_lui};
      end else if (r[3:0] == 4'd3) begin
        prog[i] = {v[31:12], rd, op_auipc};
      end else if (r[3:0] < 4'd10) begin
        imm = v[31:20];
        if (f3 == 3'd1) imm[11:5] = 7'h00;
        if (f3 == 3'd5) imm[11:5] = {1'b0, v[30], 5'd0};
        prog[i] = {imm, s1, f3, rd, op_reg_imm};
      end else begin
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && v[30]) ? 7'h20 : 7'h00;
        prog[i] = {f7, s2, s1, f3, rd, op_reg_reg};
      end
      recent[2] = recent[1];
      recent[1] = recent[0];
      recent[0] = rd;
    end
  end
  prog[prog_len - 1] = ecall_insn;
endtask

// anything outside the program reads as ecall
function automatic insn_t fetch_word(word_t pc);
  word_t idx;
  idx = (pc - start_pc) >> 2;
  if (pc < start_pc || idx >= prog_len) return ecall_insn;
  return prog[idx[7:0]];
endfunction

// alt selects sub for funct3 0 and arithmetic shift for funct3 5
function automatic word_t alu_op(logic [2:0] f3, logic alt, word_t a, word_t b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: return (a < b) ? 32'd1 : 32'd0;
    3'd4: return a ^ b;
    3'd5: begin
      if (alt) return $signed(a) >>> b[4:0];
      return a >> b[4:0];
    end
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

// one architectural step at model_pc
task automatic model_step(output word_t res, output logic wr, output logic taken);
  insn_t      w;
  word_t      a;
  word_t      b;
  word_t      imm_i;
  word_t      imm_b;
  logic [2:0] f3;
  w = fetch_word(model_pc);
  a = xreg[w[19:15]];
  b = xreg[w[24:20]];
  f3 = w[14:12];
  imm_i = {{20{w[31]}}, w[31:20]};
  imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
  res = '0;
  wr = 1'b0;
  taken = 1'b0;
  case (w[6:0])
    op_reg_imm: begin
      res = alu_op(f3, f3 == 3'd5 && w[30], a, imm_i);
      wr = 1'b1;
    end
    op_reg_reg: begin
      res = alu_op(f3, w[30], a, b);
      wr = 1'b1;
    end
    op_lui: begin
      res = {w[31:12], 12'd0};
      wr = 1'b1;
    end
    op_auipc: begin
      res = model_pc + {w[31:12], 12'd0};
      wr = 1'b1;
    end
    op_branch: begin
      case (f3)
        3'd0: taken = a == b;
        3'd1: taken = a != b;
        3'd4: taken = $signed(a) < $signed(b);
        3'd5: taken = $signed(a) >= $signed(b);
        3'd6: taken = a < b;
        default: taken = a >= b;
      endcase
    end
    default: ;
  endcase
  // x0 stays zero
  if (wr && w[11:7] != 5'd0) xreg[w[11:7]] = res;
  else wr = 1'b0;
  model_pc = taken ? model_pc + imm_b : model_pc + 32'd4;
endtask

/* sim/rv_pipeline_tb.sv */
module rv_pipeline_tb
  import rv_pkg::*;
();

  localparam int period = 4;
  localparam word_t start_pc = 32'h0000_0100;

  logic          clk = 1'b0;
  logic          rst;
  word_t         imem_pc;
  insn_t         imem_insn;
  logic          halt;
  word_t         trace_pc;
  insn_t         trace_insn;
  cycle_status_e trace_status;
  word_t         trace_data;

  `include "rv_model.svh"

  // every instruction costs at most three cycles, a taken branch included
  localparam int timeout_cycles = prog_len * 3 + 50;

  int    errors = 0;
  int    retired = 0;
  int    bubbles = 0;
  logic  started = 1'b0;
  logic  done = 1'b0;
  insn_t exp_insn;
  word_t exp_result;
  logic  exp_wr;
  logic  exp_taken;

  rv_pipeline #(
    .reset_pc (start_pc)
  ) uut (
    .clk          (clk),
    .rst          (rst),
    .imem_pc      (imem_pc),
    .imem_insn    (imem_insn),
    .halt         (halt),
    .trace_pc     (trace_pc),
    .trace_insn   (trace_insn),
    .trace_status (trace_status),
    .trace_data   (trace_data)
  );

  always #(period / 2) clk = ~clk;

  task automatic compare(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      errors++;
      $display("Fail %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // instruction memory answers the pc on every falling edge
  task automatic next_cycle();
    @(negedge clk);
    imem_insn = fetch_word(imem_pc);
  endtask

  initial begin
    rst = 1'b1;
    imem_insn = nop_insn;
    gen_program();
    xreg = '{default: '0};
    model_pc = start_pc;
    repeat (10) next_cycle();
    rst = 1'b0;
    while (!done) begin
      next_cycle();
      if (trace_status == cycle_reset) begin
        if (started) begin
          errors++;
          $display("a reset slot reached the trace after the first instruction");
        end
        compare("halt after reset", '0, word_t'(halt));
      end else if (bubbles > 0) begin
        compare("flush status", word_t'(cycle_taken_branch), word_t'(trace_status));
        compare("flush insn", nop_insn, trace_insn);
        bubbles--;
      end else begin
        started = 1'b1;
        exp_insn = fetch_word(model_pc);
        compare("retire status", word_t'(cycle_no_stall), word_t'(trace_status));
        compare("retire pc", model_pc, trace_pc);
        compare("retire insn", exp_insn, trace_insn);
        model_step(exp_result, exp_wr, exp_taken);
        if (exp_wr) compare("retire result", exp_result, trace_data);
        // two squashed slots follow a taken branch
        if (exp_taken) bubbles = 2;
        retired++;
        done = (exp_insn == ecall_insn);
      end
    end
    compare("halt at ecall", 32'd1, word_t'(halt));
    $display("%0d instructions retired, %0d errors", retired, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    #(period * (timeout_cycles + 10));
    $display("timeout, ecall did not retire within %0d cycles", timeout_cycles);
    $display("%0d instructions retired, %0d errors", retired, errors);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
